// ==== src/decodePkg.sv ====
package decodePkg;

    //////////////////////////////////////////////////
    // Word and field widths
    //////////////////////////////////////////////////

    localparam int instWidth    = 32;
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth     = 22;

    // Depth of the register file
    localparam int regCount = 2 ** regAddrWidth;

    //////////////////////////////////////////////////
    // Instruction field positions
    //////////////////////////////////////////////////

    localparam int opcodeHi = 31;
    localparam int opcodeLo = 27;

    // Destination register
    localparam int rdsHi = 26;
    localparam int rdsLo = 22;

    // Store data or branch source, same slot as rds
    localparam int rstHi = 26;
    localparam int rstLo = 22;

    localparam int rs1Hi = 21;
    localparam int rs1Lo = 17;

    // Bit 16 left free between rs1 and rs2
    localparam int rs2Hi = 15;
    localparam int rs2Lo = 11;

    // Immediate overlaps rs1 and rs2
    localparam int immHi = 21;
    localparam int immLo = 0;

    // Opcode encodings, unlisted codes behave as opNop
    typedef enum logic [4:0] {
        opAlu      = 5'h00,
        opAluImm   = 5'h01,
        opLogicImm = 5'h02,
        opLoad     = 5'h03,
        opStore    = 5'h04,
        opBranch   = 5'h05,
        opJump     = 5'h06,
        opNop      = 5'h07
    } opcodeT;

    // Immediate extension modes
    typedef enum logic [1:0] {
        ext22  = 2'd0,  // jump offset, sign from bit 21
        ext17  = 2'd1,  // load, store, signed immediate
        ext12  = 2'd2,  // branch offset, sign from bit 11
        zero17 = 2'd3   // logic immediate, no sign
    } extModeT;

endpackage

// ==== src/registerFile.sv ====
`timescale 1ns/1ns

module registerFile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [decodePkg::regAddrWidth-1:0] rAddr1,
    input  logic [decodePkg::regAddrWidth-1:0] rAddr2,
    input  logic                                we,
    input  logic [decodePkg::regAddrWidth-1:0] wAddr,
    input  logic [decodePkg::dataWidth-1:0]    wData,
    output logic [decodePkg::dataWidth-1:0]    rData1,
    output logic [decodePkg::dataWidth-1:0]    rData2
);

    // Register storage
    logic [decodePkg::dataWidth-1:0] regs [decodePkg::regCount];

    // Write enable qualified against register 0
    logic wrValid;

    assign wrValid = we && (wAddr != '0);

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    // Reset wipes the whole array
    // Writes land on the rising edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < decodePkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrValid) begin
            regs[wAddr] <= wData;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Combinational, so a same-cycle write shows up next cycle
    // Register 0 hardwired to zero
    assign rData1 = (rAddr1 == '0) ? '0 : regs[rAddr1];
    assign rData2 = (rAddr2 == '0) ? '0 : regs[rAddr2];

endmodule

// ==== src/ctrlUnit.sv ====
`timescale 1ns/1ns

module ctrlUnit (
    input  decodePkg::opcodeT  opcode,
    output logic               r2Select,
    output decodePkg::extModeT extMode,
    output logic               writesRd,
    output logic               usesImm
);

    //////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////

    // Purely combinational, opcode only
    // Branch condition bits not looked at here
    always_comb begin
        // Defaults match a nop
        r2Select = 1'b0;
        extMode  = decodePkg::ext17;
        writesRd = 1'b0;
        usesImm  = 1'b0;

        case (opcode)
            // Register-register
            decodePkg::opAlu: begin
                writesRd = 1'b1;
            end

            // Signed immediate replaces operand 2
            decodePkg::opAluImm: begin
                extMode  = decodePkg::ext17;
                writesRd = 1'b1;
                usesImm  = 1'b1;
            end

            // Logic ops want the raw bits
            decodePkg::opLogicImm: begin
                extMode  = decodePkg::zero17;
                writesRd = 1'b1;
                usesImm  = 1'b1;
            end

            // Address is rs1 plus offset
            decodePkg::opLoad: begin
                extMode  = decodePkg::ext17;
                writesRd = 1'b1;
                usesImm  = 1'b1;
            end

            // Store data comes from the rst slot
            decodePkg::opStore: begin
                r2Select = 1'b1;
                extMode  = decodePkg::ext17;
                usesImm  = 1'b1;
            end

            // Compare rs1 against rst, offset kept aside
            decodePkg::opBranch: begin
                r2Select = 1'b1;
                extMode  = decodePkg::ext12;
            end

            // Long offset, link goes to rds
            decodePkg::opJump: begin
                extMode  = decodePkg::ext22;
                writesRd = 1'b1;
                usesImm  = 1'b1;
            end

            // opNop and every unknown code
            default: begin
                writesRd = 1'b0;
                usesImm  = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/idStage.sv ====
`timescale 1ns/1ns

module idStage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [decodePkg::instWidth-1:0]    instr,

    // Write port, driven by the later stages
    input  logic                                rfWe,
    input  logic [decodePkg::regAddrWidth-1:0] wAddr,
    input  logic [decodePkg::dataWidth-1:0]    wData,

    // Forwarding for operand 2
    input  logic [decodePkg::dataWidth-1:0]    fwdRs2,
    input  logic                                fwdRs2Sel,

    // From ctrlUnit
    input  logic                                r2Select,
    input  decodePkg::extModeT                  extMode,

    output logic [decodePkg::regAddrWidth-1:0] rdsAddr,
    output logic [decodePkg::regAddrWidth-1:0] rs1Addr,
    output logic [decodePkg::regAddrWidth-1:0] rs2Addr,
    output logic [decodePkg::dataWidth-1:0]    op1,
    output logic [decodePkg::dataWidth-1:0]    op2,
    output logic [decodePkg::dataWidth-1:0]    imm
);

    logic [decodePkg::regAddrWidth-1:0] rs2Field;
    logic [decodePkg::regAddrWidth-1:0] rstField;
    logic [decodePkg::dataWidth-1:0]    rfRs2;
    logic [decodePkg::immWidth-1:0]     immField;

    //////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////

    assign rdsAddr  = instr[decodePkg::rdsHi:decodePkg::rdsLo];
    assign rs1Addr  = instr[decodePkg::rs1Hi:decodePkg::rs1Lo];
    assign rs2Field = instr[decodePkg::rs2Hi:decodePkg::rs2Lo];
    assign rstField = instr[decodePkg::rstHi:decodePkg::rstLo];
    assign immField = instr[decodePkg::immHi:decodePkg::immLo];

    // Store and branch read rst on port 2
    assign rs2Addr = r2Select ? rstField : rs2Field;

    //////////////////////////////////////////////////
    // Operand fetch
    //////////////////////////////////////////////////

    registerFile regFile (
        .clk    (clk),
        .reset  (reset),
        .rAddr1 (rs1Addr),
        .rAddr2 (rs2Addr),
        .we     (rfWe),
        .wAddr  (wAddr),
        .wData  (wData),
        .rData1 (op1),
        .rData2 (rfRs2)
    );

    // Bypass overrides the array read
    assign op2 = fwdRs2Sel ? fwdRs2 : rfRs2;

    //////////////////////////////////////////////////
    // Immediate extension
    //////////////////////////////////////////////////

    always_comb begin
        case (extMode)
            // Full 22 bits
            decodePkg::ext22:
                imm = {{(decodePkg::dataWidth - 22){immField[21]}}, immField};
            // Low 17 bits, signed
            decodePkg::ext17:
                imm = {{(decodePkg::dataWidth - 17){immField[16]}}, immField[16:0]};
            // Low 12 bits, signed
            decodePkg::ext12:
                imm = {{(decodePkg::dataWidth - 12){immField[11]}}, immField[11:0]};
            // Low 17 bits, upper bits cleared
            default:
                imm = {{(decodePkg::dataWidth - 17){1'b0}}, immField[16:0]};
        endcase
    end

endmodule

// ==== src/decodeTop.sv ====
`timescale 1ns/1ns

module decodeTop (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [decodePkg::instWidth-1:0]    instr,

    // Write-back side
    input  logic                                rfWe,
    input  logic [decodePkg::regAddrWidth-1:0] wAddr,
    input  logic [decodePkg::dataWidth-1:0]    wData,

    // Forwarding side
    input  logic [decodePkg::dataWidth-1:0]    fwdRs2,
    input  logic                                fwdRs2Sel,

    output logic [decodePkg::regAddrWidth-1:0] rdsAddr,
    output logic [decodePkg::regAddrWidth-1:0] rs1Addr,
    output logic [decodePkg::regAddrWidth-1:0] rs2Addr,
    output logic [decodePkg::dataWidth-1:0]    op1,
    output logic [decodePkg::dataWidth-1:0]    op2,
    output logic [decodePkg::dataWidth-1:0]    imm,
    output logic                                writesRd,
    output logic                                usesImm
);

    // Control to datapath
    decodePkg::opcodeT  opcode;
    decodePkg::extModeT extMode;
    logic               r2Select;

    // Top opcode bits, unknown codes pass through as-is
    assign opcode = decodePkg::opcodeT'(instr[decodePkg::opcodeHi:decodePkg::opcodeLo]);

    //////////////////////////////////////////////////
    // Control and datapath
    //////////////////////////////////////////////////

    ctrlUnit ctrl (
        .opcode   (opcode),
        .r2Select (r2Select),
        .extMode  (extMode),
        .writesRd (writesRd),
        .usesImm  (usesImm)
    );

    idStage decode (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .rfWe      (rfWe),
        .wAddr     (wAddr),
        .wData     (wData),
        .fwdRs2    (fwdRs2),
        .fwdRs2Sel (fwdRs2Sel),
        .r2Select  (r2Select),
        .extMode   (extMode),
        .rdsAddr   (rdsAddr),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .op1       (op1),
        .op2       (op2),
        .imm       (imm)
    );

endmodule

// ==== tb/decodeTopTb.sv ====
`timescale 1ns/1ns

module decodeTopTb;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        rfWe;
    logic [4:0]  wAddr;
    logic [31:0] wData;
    logic [31:0] fwdRs2;
    logic        fwdRs2Sel;
    logic [4:0]  rdsAddr;
    logic [4:0]  rs1Addr;
    logic [4:0]  rs2Addr;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] imm;
    logic        writesRd;
    logic        usesImm;

    // Register file mirror
    logic [31:0] model [32];

    // Write driven this cycle, lands on the next edge
    logic        pendWe;
    logic [4:0]  pendAddr;
    logic [31:0] pendData;

    logic [31:0] rngState;
    string       testName;
    int          testErrors;
    int          checkCount;
    int          mismatchCount;
    int          testsRun;
    int          testsFailed;
    bit          resetOk;

    decodeTop DUT (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .rfWe      (rfWe),
        .wAddr     (wAddr),
        .wData     (wData),
        .fwdRs2    (fwdRs2),
        .fwdRs2Sel (fwdRs2Sel),
        .rdsAddr   (rdsAddr),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .op1       (op1),
        .op2       (op2),
        .imm       (imm),
        .writesRd  (writesRd),
        .usesImm   (usesImm)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Held high for 5 rising edges
    initial begin
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // xorshift32
    function logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Destination write for alu, both immediates, load, jump link
    function automatic logic expWritesRd(logic [4:0] op);
        return op == decodePkg::opAlu || op == decodePkg::opAluImm
            || op == decodePkg::opLogicImm || op == decodePkg::opLoad
            || op == decodePkg::opJump;
    endfunction

    // Immediate in place of operand 2
    function automatic logic expUsesImm(logic [4:0] op);
        return op == decodePkg::opAluImm || op == decodePkg::opLogicImm
            || op == decodePkg::opLoad || op == decodePkg::opStore
            || op == decodePkg::opJump;
    endfunction

    // Store and branch read the rst slot
    function automatic logic [4:0] expRs2Addr(logic [31:0] word);
        logic [4:0] op;
        op = word[31:27];
        if (op == decodePkg::opStore || op == decodePkg::opBranch) begin
            return word[26:22];
        end
        return word[15:11];
    endfunction

    function automatic logic [31:0] expImm(logic [31:0] word);
        logic [4:0] op;
        op = word[31:27];
        if (op == decodePkg::opJump) begin
            return {{10{word[21]}}, word[21:0]};
        end else if (op == decodePkg::opBranch) begin
            return {{20{word[11]}}, word[11:0]};
        end else if (op == decodePkg::opLogicImm) begin
            return {15'd0, word[16:0]};
        end
        // Nop and unknown codes fall into the signed 17-bit case
        return {{15{word[16]}}, word[16:0]};
    endfunction

    //////////////////////////////////////////////////
    // Drive and check
    //////////////////////////////////////////////////

    task automatic checkValue(string field, logic [31:0] expV, logic [31:0] actV);
        checkCount++;
        if (actV !== expV) begin
            $display("[FAIL] %s %s expected %h actual %h", testName, field, expV, actV);
            testErrors++;
        end
    endtask

    // One clock: drive on the edge, check at the falling edge
    task automatic applyCycle(input logic [31:0] word, input logic we, input logic [4:0] wa,
                              input logic [31:0] wd, input logic [31:0] fwd,
                              input logic fwdSel);
        logic [4:0] r2;
        @(posedge clk);
        if (pendWe && pendAddr != 5'd0) begin
            model[pendAddr] = pendData;
        end
        instr     <= word;
        rfWe      <= we;
        wAddr     <= wa;
        wData     <= wd;
        fwdRs2    <= fwd;
        fwdRs2Sel <= fwdSel;
        pendWe   = we;
        pendAddr = wa;
        pendData = wd;
        @(negedge clk);
        // Model not yet updated, so a same-cycle read expects the old word
        r2 = expRs2Addr(word);
        checkValue("rdsAddr", 32'(word[26:22]), 32'(rdsAddr));
        checkValue("rs1Addr", 32'(word[21:17]), 32'(rs1Addr));
        checkValue("rs2Addr", 32'(r2), 32'(rs2Addr));
        checkValue("op1", model[word[21:17]], op1);
        checkValue("op2", fwdSel ? fwd : model[r2], op2);
        checkValue("imm", expImm(word), imm);
        checkValue("writesRd", 32'(expWritesRd(word[31:27])), 32'(writesRd));
        checkValue("usesImm", 32'(expUsesImm(word[31:27])), 32'(usesImm));
    endtask

    // Random word with a chosen opcode, random write, optional bypass
    task automatic randomCycle(input logic [4:0] op, input logic fwdOn);
        logic [31:0] r;
        logic [31:0] word;
        r = nextRand();
        word = nextRand();
        word[31:27] = op;
        applyCycle(word, r[8], r[13:9], nextRand(), nextRand(), fwdOn & r[0]);
    endtask

    task automatic waitResetRelease(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (cycles < 20 && !ok) begin
            @(posedge clk);
            cycles++;
            ok = (reset == 1'b0);
        end
    endtask

    task automatic startTest(string name);
        testName = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        testsRun++;
        mismatchCount += testErrors;
        if (testErrors == 0) begin
            $display("[PASS] %s", testName);
        end else begin
            $display("Test %s finished with %0d mismatches", testName, testErrors);
            testsFailed++;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] word;
        logic [31:0] r;
        logic [4:0]  wa;
        rngState = 32'h6fc7_3286;
        instr     <= '0;
        rfWe      <= 1'b0;
        wAddr     <= '0;
        wData     <= '0;
        fwdRs2    <= '0;
        fwdRs2Sel <= 1'b0;
        pendWe   = 1'b0;
        pendAddr = '0;
        pendData = '0;
        testErrors    = 0;
        checkCount    = 0;
        mismatchCount = 0;
        testsRun      = 0;
        testsFailed   = 0;
        for (int a = 0; a < 32; a++) begin
            model[a] = '0;
        end

        waitResetRelease(resetOk);
        if (!resetOk) begin
            $display("Timeout: reset still high after 20 clock cycles");
            testsFailed++;
        end else begin
            // Sweep both ports over every address
            startTest("resetZero");
            for (int a = 0; a < 32; a++) begin
                word = {5'(decodePkg::opAlu), 5'd0, 5'(a), 1'b0, 5'(31 - a), 11'd0};
                applyCycle(word, 1'b0, 5'd0, 32'd0, 32'd0, 1'b0);
            end
            endTest();

            startTest("regWrite");
            for (int i = 0; i < 200; i++) begin
                r = nextRand();
                wa = (i % 8 == 0) ? 5'd0 : r[4:0];
                word = nextRand();
                word[31:27] = 5'(decodePkg::opAlu);
                // Same-cycle read of the address being written
                if (r[5]) word[21:17] = wa;
                if (r[6]) word[15:11] = wa;
                applyCycle(word, 1'b1, wa, nextRand(), 32'd0, 1'b0);
            end
            for (int a = 0; a < 32; a++) begin
                word = {5'(decodePkg::opAlu), 5'd0, 5'(a), 1'b0, 5'(a), 11'd0};
                applyCycle(word, 1'b0, 5'd0, 32'd0, 32'd0, 1'b0);
            end
            endTest();

            startTest("fields");
            for (int i = 0; i < 200; i++) randomCycle(5'(i % 8), 1'b0);
            endTest();

            startTest("forwarding");
            for (int i = 0; i < 200; i++) randomCycle(5'(i % 8), 1'b1);
            endTest();

            // Every sign-bit combination under every opcode
            startTest("immediate");
            for (int i = 0; i < 256; i++) begin
                word = nextRand();
                word[31:27] = 5'(i % 8);
                word[21] = i[3];
                word[16] = i[4];
                word[11] = i[5];
                applyCycle(word, 1'b0, 5'd0, 32'd0, nextRand(), i[6]);
            end
            endTest();

            // Codes 8 to 31 behave as nop
            startTest("control");
            for (int i = 0; i < 256; i++) randomCycle(5'(i % 32), 1'b1);
            endTest();
        end

        $display("Tests run %0d, failed %0d, checks %0d, mismatches %0d",
                 testsRun, testsFailed, checkCount, mismatchCount);
        if (testsFailed == 0 && mismatchCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/decodePkg.sv
src/registerFile.sv
src/ctrlUnit.sv
src/idStage.sv
src/decodeTop.sv
tb/decodeTopTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := decodeTopTb
FILELIST  := verilog.f
OBJDIR    := obj_dir
LOG       := sim.log
PASSMSG   := All tests passed!
FAILMSG   := Test failures found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "$(PASSMSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
